/* Makefile */
TOP = tb_timestamp_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module timestamp_core

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* source/sync_fifo.sv */
/*
 * Single-clock first-word-fall-through FIFO, payload type set by parameter
 */
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  wire                           BUS_CLK,
    input  wire                           RST,
    input  wire                           write,
    input  wire payload_t                 wdata,
    input  wire                           read,
    output payload_t                      rdata,
    output logic                          full,
    output logic                          empty,
    output logic [$clog2(DEPTH+1)-1:0]    free
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;     // entries held
    logic             do_write;
    logic             do_read;

    assign do_write = write && !full;
    assign do_read  = read && !empty;

    always_ff @(posedge BUS_CLK) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // both or neither keeps the level
            endcase
        end
    end

    assign rdata = mem[rd_ptr];      // head is always visible
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign free  = CNT_W'(DEPTH) - count;

    a_no_overflow : assert property (@(posedge BUS_CLK) disable iff (RST)
        write |-> !full);
    a_no_underflow : assert property (@(posedge BUS_CLK) disable iff (RST)
        read |-> !empty);

endmodule

`default_nettype wire

/* source/timestamp_consts.svh */
/*
 * Timestamp recorder constants: version, source identifier,
 * register map and FIFO depths
 */
`ifndef TIMESTAMP_CONSTS_SVH
`define TIMESTAMP_CONSTS_SVH

`define TS_VERSION      8'd2     // value returned by a read of address 0
`define TS_IDENTIFIER   4'b0001  // source id in bits 31-28 of every output word

`define TS_ADDR_RESET   16'd0    // any write here is a soft reset
`define TS_ADDR_CONF    16'd2
`define TS_ADDR_LOST    16'd3

`define TS_RECORD_DEPTH 4        // records waiting to be split
`define TS_WORD_DEPTH   16       // tagged 32-bit words for the host

`endif

/* source/timestamp_core.sv */
/*
 * Timestamp recorder top: register block, capture counter,
 * record FIFO, word splitter and the host-side word FIFO
 */
`default_nettype none

`include "timestamp_consts.svh"

module timestamp_core (
    input  wire                          BUS_CLK,
    input  wire                          RST,
    input  wire [15:0]                   BUS_ADD,
    input  wire [7:0]                    BUS_DATA_IN,
    input  wire                          BUS_WR,
    input  wire                          BUS_RD,
    output wire [7:0]                    BUS_DATA_OUT,
    input  wire                          DI,
    input  wire                          EXT_ENABLE,
    input  wire [63:0]                   EXT_TIMESTAMP,
    output wire [63:0]                   TIMESTAMP_OUT,
    input  wire                          FIFO_READ,
    output wire                          FIFO_EMPTY,
    output wire timestamp_pkg::out_word_t FIFO_DATA
);
    import timestamp_pkg::*;

    ts_conf_t   conf;
    logic       soft_rst;
    logic       core_rst;     // bus reset or soft reset
    logic [7:0] lost_cnt;

    logic       capture;
    ts_record_t record;
    logic       rec_full;
    logic       rec_empty;
    logic       rec_read;
    ts_record_t rec_data;

    logic                                 word_write;
    out_word_t                            word;
    logic [$clog2(`TS_WORD_DEPTH+1)-1:0]  word_free;

    assign core_rst      = RST | soft_rst;
    assign TIMESTAMP_OUT = record.stamp;

    timestamp_regs u_regs (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),
        .BUS_ADD      (BUS_ADD),
        .BUS_DATA_IN  (BUS_DATA_IN),
        .BUS_WR       (BUS_WR),
        .BUS_RD       (BUS_RD),
        .lost_cnt     (lost_cnt),
        .BUS_DATA_OUT (BUS_DATA_OUT),
        .conf         (conf),
        .soft_rst     (soft_rst)
    );

    timestamp_counter u_counter (
        .BUS_CLK       (BUS_CLK),
        .RST           (core_rst),
        .DI            (DI),
        .EXT_ENABLE    (EXT_ENABLE),
        .EXT_TIMESTAMP (EXT_TIMESTAMP),
        .conf          (conf),
        .record_full   (rec_full),
        .capture       (capture),
        .record        (record),
        .lost_cnt      (lost_cnt)
    );

    sync_fifo #(
        .payload_t (ts_record_t),
        .DEPTH     (`TS_RECORD_DEPTH)
    ) u_record_fifo (
        .BUS_CLK (BUS_CLK),
        .RST     (core_rst),
        .write   (capture),
        .wdata   (record),
        .read    (rec_read),
        .rdata   (rec_data),
        .full    (rec_full),
        .empty   (rec_empty),
        .free    ()
    );

    word_splitter_fsm u_splitter (
        .BUS_CLK    (BUS_CLK),
        .RST        (core_rst),
        .rec_empty  (rec_empty),
        .rec_data   (rec_data),
        .word_free  (word_free),
        .rec_read   (rec_read),
        .word_write (word_write),
        .word       (word)
    );

    // host pops tagged words straight from this FIFO
    sync_fifo #(
        .payload_t (out_word_t),
        .DEPTH     (`TS_WORD_DEPTH)
    ) u_word_fifo (
        .BUS_CLK (BUS_CLK),
        .RST     (core_rst),
        .write   (word_write),
        .wdata   (word),
        .read    (FIFO_READ),
        .rdata   (FIFO_DATA),
        .full    (),
        .empty   (FIFO_EMPTY),
        .free    (word_free)
    );

endmodule

`default_nettype wire

/* source/timestamp_counter.sv */
/*
 * Free-running cycle counter with DI edge capture, two-cycle lock-out
 * and a saturating count of captures dropped on a full record FIFO
 */
`default_nettype none

module timestamp_counter (
    input  wire                       BUS_CLK,
    input  wire                       RST,
    input  wire                       DI,
    input  wire                       EXT_ENABLE,
    input  wire [63:0]                EXT_TIMESTAMP,
    input  wire timestamp_pkg::ts_conf_t conf,
    input  wire                       record_full,
    output logic                      capture,
    output timestamp_pkg::ts_record_t record,
    output logic [7:0]                lost_cnt
);
    import timestamp_pkg::*;

    logic [1:0]  di_ff;        // di_ff[0] is the first stage
    logic        di_rise;
    logic [63:0] free_cnt;
    logic        enable;
    logic [1:0]  lock;         // 1 right after a capture, 2 when the write is due
    logic        capture_due;
    ts_record_t  next_stamp;

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            di_ff    <= 2'b00;
            free_cnt <= 64'd0;
        end else begin
            di_ff    <= {di_ff[0], DI};
            free_cnt <= free_cnt + 64'd1;
        end
    end

    assign di_rise = di_ff[0] & ~di_ff[1];
    assign enable  = conf.en | (conf.ext_enable & EXT_ENABLE);

    always_comb begin
        next_stamp.stamp = conf.ext_timestamp ? EXT_TIMESTAMP : free_cnt;
    end

    // every edge takes the same path, so stamp spacing equals edge spacing
    always_ff @(posedge BUS_CLK) begin
        if (RST || !enable) begin
            lock   <= 2'd0;
            record <= '0;
        end else if (di_rise && lock == 2'd0) begin
            record <= next_stamp;
            lock   <= 2'd1;
        end else if (lock == 2'd1) begin
            lock <= 2'd2;
        end else begin
            lock <= 2'd0;
        end
    end

    assign capture_due = (lock == 2'd2);
    assign capture     = capture_due & ~record_full;  // a full FIFO drops the record

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            lost_cnt <= 8'd0;
        end else if (capture_due && record_full && lost_cnt != 8'hff) begin
            lost_cnt <= lost_cnt + 8'd1;
        end
    end

    a_capture_single : assert property (@(posedge BUS_CLK) disable iff (RST)
        capture |=> !capture);

endmodule

`default_nettype wire

/* source/timestamp_pkg.sv */
/*
 * Shared types of the timestamp recorder: configuration bits,
 * captured record and the tagged 32-bit output word
 */
`default_nettype none

package timestamp_pkg;

    // field order puts en in bit 0, ext_timestamp in bit 1, ext_enable in bit 2
    typedef struct packed {
        logic ext_enable;
        logic ext_timestamp;
        logic en;
    } ts_conf_t;

    typedef struct packed {
        logic [63:0] stamp;
    } ts_record_t;

    typedef enum logic [3:0] {
        KIND_LOW  = 4'd1,
        KIND_MID  = 4'd2,
        KIND_HIGH = 4'd3
    } word_kind_t;

    typedef struct packed {
        logic [3:0]  id;
        word_kind_t  kind;
        logic [23:0] payload;
    } out_word_t;

endpackage

`default_nettype wire

/* source/timestamp_regs.sv */
/*
 * Register block on the 8-bit bus: soft reset, version,
 * configuration bits and the lost-capture count
 */
`default_nettype none

`include "timestamp_consts.svh"

module timestamp_regs (
    input  wire                     BUS_CLK,
    input  wire                     RST,
    input  wire [15:0]              BUS_ADD,
    input  wire [7:0]               BUS_DATA_IN,
    input  wire                     BUS_WR,
    input  wire                     BUS_RD,
    input  wire [7:0]               lost_cnt,
    output logic [7:0]              BUS_DATA_OUT,
    output timestamp_pkg::ts_conf_t conf,
    output logic                    soft_rst
);
    import timestamp_pkg::*;

    logic conf_write;

    // combinational so the reset lands on the same edge as the write
    assign soft_rst   = BUS_WR && (BUS_ADD == `TS_ADDR_RESET);
    assign conf_write = BUS_WR && (BUS_ADD == `TS_ADDR_CONF);

    always_ff @(posedge BUS_CLK) begin
        if (RST || soft_rst) begin
            conf <= '0;
        end else if (conf_write) begin
            conf <= ts_conf_t'(BUS_DATA_IN[2:0]);
        end
    end

    // read data appears the cycle after BUS_RD and is held until the next read
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RD) begin
            case (BUS_ADD)
                `TS_ADDR_RESET: BUS_DATA_OUT <= `TS_VERSION;
                `TS_ADDR_CONF:  BUS_DATA_OUT <= {5'b00000, conf};
                `TS_ADDR_LOST:  BUS_DATA_OUT <= lost_cnt;
                default:        BUS_DATA_OUT <= 8'h00;
            endcase
        end
    end

    // write strobes last one cycle, so a soft reset is a single pulse
    a_soft_rst_pulse : assert property (@(posedge BUS_CLK) disable iff (RST)
        soft_rst |=> !soft_rst);

endmodule

`default_nettype wire

/* source/word_splitter_fsm.sv */
/*
 * Splits each 64-bit record into LOW, MID and HIGH tagged words
 * written on three consecutive cycles
 */
`default_nettype none

`include "timestamp_consts.svh"

module word_splitter_fsm (
    input  wire                                 BUS_CLK,
    input  wire                                 RST,
    input  wire                                 rec_empty,
    input  wire timestamp_pkg::ts_record_t      rec_data,
    input  wire [$clog2(`TS_WORD_DEPTH+1)-1:0]  word_free,
    output logic                                rec_read,
    output logic                                word_write,
    output timestamp_pkg::out_word_t            word
);
    import timestamp_pkg::*;

    localparam int FREE_W = $clog2(`TS_WORD_DEPTH + 1);

    typedef enum logic [1:0] {
        IDLE,
        LOW,
        MID,
        HIGH
    } state_t;

    state_t     state;
    ts_record_t rec_buf;     // record being split

    // room for all three words is checked up front, so no stall mid-record
    assign rec_read = (state == IDLE) && !rec_empty && (word_free >= FREE_W'(3));

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    state <= rec_read ? LOW : IDLE;
                LOW:     state <= MID;
                MID:     state <= HIGH;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (rec_read) begin
            rec_buf <= rec_data;
        end
    end

    assign word_write = (state != IDLE);

    always_comb begin
        word    = '0;
        word.id = `TS_IDENTIFIER;
        case (state)
            LOW: begin
                word.kind    = KIND_LOW;
                word.payload = rec_buf.stamp[23:0];
            end
            MID: begin
                word.kind    = KIND_MID;
                word.payload = rec_buf.stamp[47:24];
            end
            HIGH: begin
                word.kind    = KIND_HIGH;
                word.payload = {8'h00, rec_buf.stamp[63:48]};
            end
            default: word.kind = KIND_LOW;
        endcase
    end

    a_three_words : assert property (@(posedge BUS_CLK) disable iff (RST)
        rec_read |=> word_write ##1 word_write ##1 word_write ##1 !word_write);

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/timestamp_pkg.sv
source/sync_fifo.sv
source/timestamp_regs.sv
source/timestamp_counter.sv
source/word_splitter_fsm.sv
source/timestamp_core.sv
tests/tb_timestamp_core.sv

/* tests/tb_timestamp_core.sv */
/*
 * Self-checking testbench for the timestamp recorder: runs the operations
 * of the cases file and checks registers, tagged words and lost captures
 */
`default_nettype none

`include "timestamp_consts.svh"

module tb_timestamp_core;
    timeunit 1ns;
    timeprecision 1ps;

    import timestamp_pkg::*;

    // 5 records fit the word FIFO (3 words each) plus a full record FIFO
    localparam int CAPACITY = `TS_RECORD_DEPTH + `TS_WORD_DEPTH / 3;

    typedef struct packed {
        logic        internal;   // stamp comes from the free-running counter
        logic [63:0] value;      // EXT_TIMESTAMP, or the tb cycle of the DI rise
    } expect_t;

    logic        BUS_CLK = 1'b0;
    logic        RST;
    logic [15:0] BUS_ADD;
    logic [7:0]  BUS_DATA_IN;
    logic        BUS_WR;
    logic        BUS_RD;
    wire  [7:0]  BUS_DATA_OUT;
    logic        DI;
    logic        EXT_ENABLE;
    logic [63:0] EXT_TIMESTAMP;
    wire  [63:0] TIMESTAMP_OUT;
    logic        FIFO_READ;
    wire         FIFO_EMPTY;
    out_word_t   FIFO_DATA;

    expect_t     exp_q[$];
    ts_conf_t    conf_model;
    logic [7:0]  lost_model;
    logic [31:0] rng = 32'h0194_8cf9;
    logic [31:0] tb_cycle = 32'd0;
    logic [63:0] anchor;         // counter value minus tb cycle, fixed until a soft reset
    logic        anchor_valid;
    logic        random_ext;
    logic        abort = 1'b0;
    int          check_errors = 0;
    int          other_errors = 0;

    timestamp_core DUT (.*);

    always #20 BUS_CLK = ~BUS_CLK;

    always @(posedge BUS_CLK) begin
        tb_cycle <= tb_cycle + 32'd1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic out_word_t make_word(input word_kind_t kind, input logic [23:0] payload);
        out_word_t w;
        w.id      = `TS_IDENTIFIER;
        w.kind    = kind;
        w.payload = payload;
        return w;
    endfunction

    task automatic next_cycle();
        @(posedge BUS_CLK);
        #2;
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input out_word_t got, input out_word_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_stamp(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        next_cycle();
        BUS_ADD     = addr;
        BUS_DATA_IN = data;
        BUS_WR      = 1'b1;
        next_cycle();
        BUS_WR = 1'b0;
        if (addr == `TS_ADDR_RESET) begin    // soft reset clears everything in the core
            conf_model   = '0;
            lost_model   = 8'd0;
            anchor_valid = 1'b0;
            exp_q.delete();
        end else if (addr == `TS_ADDR_CONF) begin
            conf_model = ts_conf_t'(data[2:0]);
        end
    endtask

    task automatic bus_read(input logic [15:0] addr, input logic [7:0] exp);
        next_cycle();
        BUS_ADD = addr;
        BUS_RD  = 1'b1;
        next_cycle();
        BUS_RD = 1'b0;
        check_byte("BUS_DATA_OUT", BUS_DATA_OUT, exp);
        if (addr == `TS_ADDR_LOST && lost_model != exp) begin
            other_errors++;
            $display("ERROR: cases file expects %0d lost captures, model counts %0d",
                     exp, lost_model);
        end
    endtask

    task automatic di_pulses(input int gap, input int count);
        expect_t     e;
        logic        enabled;
        logic [63:0] exp_out;
        int          i;
        for (i = 0; i < count; i++) begin
            repeat (gap) next_cycle();
            if (random_ext) begin
                rng = xorshift(rng);
                EXT_TIMESTAMP[63:32] = rng;
                rng = xorshift(rng);
                EXT_TIMESTAMP[31:0] = rng;
            end
            DI = 1'b1;
            enabled    = conf_model.en || (conf_model.ext_enable && EXT_ENABLE);
            e.internal = !conf_model.ext_timestamp;
            e.value    = conf_model.ext_timestamp ? EXT_TIMESTAMP : 64'(tb_cycle);
            if (enabled) begin
                if (exp_q.size() >= CAPACITY) begin
                    if (lost_model != 8'hff) lost_model++;   // saturates like the register
                end else begin
                    exp_q.push_back(e);
                end
            end
            next_cycle();
            next_cycle();
            // the stamp is taken two edges after DI rises, even when the FIFO drops it
            if (!enabled) begin
                exp_out = 64'd0;
            end else if (!e.internal) begin
                exp_out = e.value;
            end else begin
                if (!anchor_valid) begin
                    anchor       = TIMESTAMP_OUT - e.value;
                    anchor_valid = 1'b1;
                end
                exp_out = anchor + e.value;   // same offset means same edge spacing
            end
            check_stamp("TIMESTAMP_OUT", TIMESTAMP_OUT, exp_out);
            DI = 1'b0;
        end
        repeat (4) next_cycle();   // let the last capture finish its lock-out
    endtask

    task automatic read_word(output out_word_t w);
        int waited;
        waited = 0;
        w      = '0;
        while (FIFO_EMPTY && waited < 200) begin
            next_cycle();
            waited++;
        end
        if (FIFO_EMPTY) begin
            other_errors++;
            abort = 1'b1;
            $display("ERROR: no word arrived on FIFO_DATA within 200 cycles");
        end else begin
            w         = FIFO_DATA;
            FIFO_READ = 1'b1;
            next_cycle();
            FIFO_READ = 1'b0;
        end
    endtask

    task automatic drain(input int n);
        out_word_t   lo;
        out_word_t   mid;
        out_word_t   hi;
        expect_t     e;
        logic [63:0] got;
        logic [63:0] exp_stamp;
        int          k;
        int          waited;
        if (exp_q.size() != n) begin
            other_errors++;
            $display("ERROR: cases file expects %0d records, model holds %0d", n, exp_q.size());
        end
        for (k = 0; k < n && !abort; k++) begin
            read_word(lo);
            read_word(mid);
            read_word(hi);
            got = {hi.payload[15:0], mid.payload, lo.payload};
            if (!abort && exp_q.size() == 0) begin
                other_errors++;
                $display("ERROR: record %0d of the drain was never captured by the model", k);
            end else if (!abort) begin
                e = exp_q.pop_front();
                if (e.internal) begin
                    exp_stamp = anchor + e.value;   // anchor is set when the stamp is taken
                end else begin
                    exp_stamp = e.value;
                end
                check_word("FIFO_DATA low", lo, make_word(KIND_LOW, exp_stamp[23:0]));
                check_word("FIFO_DATA mid", mid, make_word(KIND_MID, exp_stamp[47:24]));
                check_word("FIFO_DATA high", hi,
                           make_word(KIND_HIGH, {8'h00, exp_stamp[63:48]}));
                check_stamp("FIFO_DATA stamp", got, exp_stamp);
            end
        end
        waited = 0;
        while (FIFO_EMPTY && waited < 20) begin
            next_cycle();
            waited++;
        end
        if (!FIFO_EMPTY) begin
            other_errors++;
            $display("ERROR: words are left in the FIFO after draining %0d records", n);
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] b;
        RST           = 1'b1;
        BUS_ADD       = 16'd0;
        BUS_DATA_IN   = 8'd0;
        BUS_WR        = 1'b0;
        BUS_RD        = 1'b0;
        DI            = 1'b0;
        EXT_ENABLE    = 1'b0;
        EXT_TIMESTAMP = 64'd0;
        FIFO_READ     = 1'b0;
        conf_model    = '0;
        lost_model    = 8'd0;
        anchor_valid  = 1'b0;
        random_ext    = 1'b0;
        repeat (4) @(posedge BUS_CLK);
        #2;
        RST = 1'b0;
        fd = $fopen("tests/timestamp_cases.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("ERROR: cannot open tests/timestamp_cases.txt");
        end else begin
            while (!abort && !$feof(fd)) begin
                line = "";
                a    = 32'd0;
                b    = 32'd0;
                void'($fgets(line, fd));
                n = $sscanf(line, "%c %h %h", op, a, b);
                if (n < 2 || op == "#") continue;   // blank or comment line
                case (op)
                    "W": bus_write(a[15:0], b[7:0]);
                    "R": bus_read(a[15:0], b[7:0]);
                    "X": begin
                        next_cycle();
                        EXT_ENABLE = a[0];
                        random_ext = b[0];
                    end
                    "P": di_pulses(a, b);
                    "D": drain(a);
                    default: begin
                        other_errors++;
                        $display("ERROR: unknown operation in cases file: %s", line);
                    end
                endcase
            end
            $fclose(fd);
        end
        $display("check errors: %0d, other errors: %0d", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/timestamp_cases.txt */
# one operation per line, all numbers in hex
# W addr data | R addr expected | X ext_enable random_ext | P gap count | D records
R 0 02
R 2 00
R 3 00
W 2 07
R 2 07
W 0 00
R 2 00
W 2 01
P 0d 2
D 2 0
W 2 03
X 0 1
P 08 3
D 3 0
W 2 04
X 1 0
P 08 2
X 0 0
P 08 2
D 2 0
W 2 00
X 1 0
P 08 2
D 0 0
W 0 00
W 2 03
X 0 1
P 10 0c
R 3 03
D 9 0
R 3 03
R 0 02
